//--- Bender.yml
package:
  name: sys_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/sys_pkg.sv
      - src/uart_pkg.sv
      - src/addr_decode.sv
      - src/block_ram.sv
      - src/uart_tx.sv
      - src/uart_rx.sv
      - src/uart_regs.sv
      - src/heartbeat.sv
      - src/sys_top.sv
      - target: test
        files:
          - tests/sys_checker.sv
          - tests/tb_sys_top.sv

//--- include/sys_config.svh
`ifndef SYS_CONFIG_SVH
`define SYS_CONFIG_SVH

// Board clock after the PLL
`define SYS_CLK_HZ 40000000
// Serial line rate
`define SYS_BAUD 115200
// RAM is 2^12 words, mirrored top and bottom
`define SYS_RAM_ADDR_BITS 12
// UART data here, status at base plus one
`define SYS_UART_BASE 16'hfe08

`endif

//--- src/addr_decode.sv
`timescale 1ns/1ps
`include "sys_config.svh"

module addr_decode
   import sys_pkg::*;
#(
   parameter int RAM_ADDR_BITS = `SYS_RAM_ADDR_BITS
) (
   input  addr_t address,
   input  word_t ram_dout,
   input  word_t uart_dout,
   output logic  ram_cs,
   output logic  uart_cs,
   output word_t dout
);

   localparam addr_t UART_BASE = `SYS_UART_BASE;

   // Address bits above the RAM
   logic [15-RAM_ADDR_BITS:0] upper;

   assign upper = address[15:RAM_ADDR_BITS];

   // Two registers, so ignore bit 0
   assign uart_cs = ({address[15:1], 1'b0} == UART_BASE);

   // RAM mirrored at bottom and top of memory, UART wins
   assign ram_cs = !uart_cs && ((upper == '0) || (&upper));

   // Read mux, unmapped reads float high
   assign dout = uart_cs ? uart_dout : (ram_cs ? ram_dout : 16'hffff);

endmodule

//--- src/block_ram.sv
`timescale 1ns/1ps
`include "sys_config.svh"

module block_ram
   import sys_pkg::*;
#(
   parameter int RAM_ADDR_BITS = `SYS_RAM_ADDR_BITS
) (
   input  logic                     clk,
   input  logic [RAM_ADDR_BITS-1:0] address,
   input  word_t                    din,
   input  logic                     rnw,
   input  logic                     cs,
   output word_t                    dout
);

   word_t mem [2**RAM_ADDR_BITS];

   // Write at the edge that ends the bus cycle
   always_ff @(posedge clk)
   begin
      if (cs && !rnw)
      begin
         mem[address] <= din;
      end
   end

   // Read data ready within the same cycle
   assign dout = mem[address];

endmodule

//--- src/heartbeat.sv
`timescale 1ns/1ps

module heartbeat (
   input  logic       clk,
   input  logic       reset_b,
   input  logic [3:0] sw,
   output logic [3:0] led
);

   // Long enough to see the LEDs blink
   logic [23:0] count;

   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         count <= '0;
      end
      else
      begin
         count <= count + 1'b1;
      end
   end

   // led[3] is led1, with sw[3..0] as sw2_1, sw2_2, sw1_1, sw1_2
   assign led = count[23:20] | sw;

endmodule

//--- src/sys_pkg.sv
// Types shared by the bus side of the system
package sys_pkg;

   // Word address driven by the bus master
   typedef logic [15:0] addr_t;

   // Data word on both the read and write buses
   typedef logic [15:0] word_t;

endpackage

//--- src/sys_top.sv
`timescale 1ns/1ps
`include "sys_config.svh"

module sys_top
   import sys_pkg::*;
#(
   parameter int CLK_HZ        = `SYS_CLK_HZ,
   parameter int BAUD          = `SYS_BAUD,
   parameter int RAM_ADDR_BITS = `SYS_RAM_ADDR_BITS
) (
   input  logic       clk,
   input  logic       reset_b,
   input  addr_t      address,
   input  word_t      din,
   input  logic       rnw,
   output word_t      dout,
   input  logic [3:0] sw,
   output logic [3:0] led,
   input  logic       rxd,
   output logic       txd
);

   logic  ram_cs;
   logic  uart_cs;
   word_t ram_dout;
   word_t uart_dout;

   // Selects and read mux
   addr_decode #(
      .RAM_ADDR_BITS (RAM_ADDR_BITS)
   ) i_addr_decode (
      .address   (address),
      .ram_dout  (ram_dout),
      .uart_dout (uart_dout),
      .ram_cs    (ram_cs),
      .uart_cs   (uart_cs),
      .dout      (dout)
   );

   // Low address bits only, which gives the mirror
   block_ram #(
      .RAM_ADDR_BITS (RAM_ADDR_BITS)
   ) i_block_ram (
      .clk     (clk),
      .address (address[RAM_ADDR_BITS-1:0]),
      .din     (din),
      .rnw     (rnw),
      .cs      (ram_cs),
      .dout    (ram_dout)
   );

   uart_regs #(
      .CLK_HZ (CLK_HZ),
      .BAUD   (BAUD)
   ) i_uart_regs (
      .clk     (clk),
      .reset_b (reset_b),
      .din     (din),
      .a0      (address[0]),
      .rnw     (rnw),
      .cs      (uart_cs),
      .rxd     (rxd),
      .dout    (uart_dout),
      .txd     (txd)
   );

   heartbeat i_heartbeat (
      .clk     (clk),
      .reset_b (reset_b),
      .sw      (sw),
      .led     (led)
   );

endmodule

//--- src/uart_pkg.sv
// Types for the serial transmitter and receiver
package uart_pkg;

   // One serial character, sent LSB first
   typedef logic [7:0] uart_byte_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_e;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

endpackage

//--- src/uart_regs.sv
`timescale 1ns/1ps
`include "sys_config.svh"

module uart_regs
   import sys_pkg::*;
   import uart_pkg::*;
#(
   parameter int CLK_HZ = `SYS_CLK_HZ,
   parameter int BAUD   = `SYS_BAUD
) (
   input  logic  clk,
   input  logic  reset_b,
   input  word_t din,
   input  logic  a0,
   input  logic  rnw,
   input  logic  cs,
   input  logic  rxd,
   output word_t dout,
   output logic  txd
);

   uart_byte_t tx_data;
   uart_byte_t rx_data;
   uart_byte_t rx_byte;
   logic       tx_start;
   logic       tx_busy;
   logic       rx_valid;
   logic       rx_full;
   logic       data_wr;
   logic       data_rd;

   // a0 low is data, high is status
   assign data_wr = cs && !rnw && !a0;
   assign data_rd = cs && rnw && !a0;

   // Writes while busy are dropped
   assign tx_start = data_wr && !tx_busy;
   assign tx_data = din[7:0];

   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         rx_full <= 1'b0;
      end
      else if (rx_valid)
      begin
         // New byte wins over a read in the same cycle
         rx_full <= 1'b1;
      end
      else if (data_rd)
      begin
         rx_full <= 1'b0;
      end
   end

   // Overwritten if the last byte was never read
   always_ff @(posedge clk)
   begin
      if (rx_valid)
      begin
         rx_byte <= rx_data;
      end
   end

   assign dout = a0 ? {14'b0, tx_busy, rx_full} : {8'b0, rx_byte};

   uart_tx #(
      .CLK_HZ (CLK_HZ),
      .BAUD   (BAUD)
   ) i_uart_tx (
      .clk      (clk),
      .reset_b  (reset_b),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .tx_busy  (tx_busy),
      .txd      (txd)
   );

   uart_rx #(
      .CLK_HZ (CLK_HZ),
      .BAUD   (BAUD)
   ) i_uart_rx (
      .clk      (clk),
      .reset_b  (reset_b),
      .rxd      (rxd),
      .rx_valid (rx_valid),
      .rx_data  (rx_data)
   );

   // Transmitter goes busy the cycle after a start
   assert property (@(posedge clk) disable iff (!reset_b)
      tx_start |=> tx_busy);

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ps
`include "sys_config.svh"

module uart_rx
   import uart_pkg::*;
#(
   parameter int CLK_HZ = `SYS_CLK_HZ,
   parameter int BAUD   = `SYS_BAUD
) (
   input  logic       clk,
   input  logic       reset_b,
   input  logic       rxd,
   output logic       rx_valid,
   output uart_byte_t rx_data
);

   localparam int BIT_CLKS = CLK_HZ / BAUD;
   localparam int HALF_CLKS = BIT_CLKS / 2;
   localparam int CW = $clog2(BIT_CLKS);

   rx_state_e     state;
   logic [2:0]    rxd_pipe;
   logic          rxd_sync;
   logic          start_edge;
   logic [CW-1:0] bit_cnt;
   logic [2:0]    bit_idx;
   logic          half_done;
   logic          bit_done;
   uart_byte_t    shift;

   // Two flops to synchronise, third for edge detect
   assign rxd_sync = rxd_pipe[1];
   assign start_edge = rxd_pipe[2] && !rxd_pipe[1];
   assign half_done = (bit_cnt == CW'(HALF_CLKS - 1));
   assign bit_done = (bit_cnt == CW'(BIT_CLKS - 1));

   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         rxd_pipe <= 3'b111;
         state    <= RX_IDLE;
         bit_cnt  <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end
      else
      begin
         rxd_pipe <= {rxd_pipe[1:0], rxd};
         rx_valid <= 1'b0;
         // Restart count at mid start bit, then full periods
         if (state == RX_IDLE || (state == RX_START && half_done) || bit_done)
         begin
            bit_cnt <= '0;
         end
         else
         begin
            bit_cnt <= bit_cnt + 1'b1;
         end
         case (state)
            RX_IDLE:
               if (start_edge)
               begin
                  state <= RX_START;
               end
            RX_START:
               // Glitch shorter than half a bit goes back to idle
               if (half_done)
               begin
                  state <= rxd_sync ? RX_IDLE : RX_DATA;
               end
            RX_DATA:
               if (bit_done)
               begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                  begin
                     state <= RX_STOP;
                  end
               end
            RX_STOP:
               if (bit_done)
               begin
                  // Framing error drops the byte
                  rx_valid <= rxd_sync;
                  state    <= RX_IDLE;
               end
            default:
               state <= RX_IDLE;
         endcase
      end
   end

   // Data bits enter at the top, LSB ends in bit 0
   always_ff @(posedge clk)
   begin
      if (state == RX_DATA && bit_done)
      begin
         shift <= {rxd_sync, shift[7:1]};
      end
      if (state == RX_STOP && bit_done && rxd_sync)
      begin
         rx_data <= shift;
      end
   end

endmodule

//--- src/uart_tx.sv
`timescale 1ns/1ps
`include "sys_config.svh"

module uart_tx
   import uart_pkg::*;
#(
   parameter int CLK_HZ = `SYS_CLK_HZ,
   parameter int BAUD   = `SYS_BAUD
) (
   input  logic       clk,
   input  logic       reset_b,
   input  logic       tx_start,
   input  uart_byte_t tx_data,
   output logic       tx_busy,
   output logic       txd
);

   localparam int BIT_CLKS = CLK_HZ / BAUD;
   localparam int CW = $clog2(BIT_CLKS);

   tx_state_e     state;
   logic [CW-1:0] bit_cnt;
   logic [2:0]    bit_idx;
   logic          bit_done;
   uart_byte_t    shift;

   // Last clock of the current bit period
   assign bit_done = (bit_cnt == CW'(BIT_CLKS - 1));
   assign tx_busy = (state != TX_IDLE);

   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         state   <= TX_IDLE;
         bit_cnt <= '0;
         bit_idx <= '0;
         txd     <= 1'b1;
      end
      else
      begin
         // Counter held at zero between frames
         bit_cnt <= (state == TX_IDLE || bit_done) ? '0 : bit_cnt + 1'b1;
         case (state)
            TX_IDLE:
               if (tx_start)
               begin
                  state <= TX_START;
                  txd   <= 1'b0;
               end
            TX_START:
               if (bit_done)
               begin
                  state <= TX_DATA;
                  txd   <= shift[0];
               end
            TX_DATA:
               if (bit_done)
               begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                  begin
                     state <= TX_STOP;
                     txd   <= 1'b1;
                  end
                  else
                  begin
                     // shift moves at this edge too
                     txd <= shift[1];
                  end
               end
            TX_STOP:
               if (bit_done)
               begin
                  state <= TX_IDLE;
               end
            default:
               state <= TX_IDLE;
         endcase
      end
   end

   // Payload shifter, LSB goes first
   always_ff @(posedge clk)
   begin
      if (state == TX_IDLE && tx_start)
      begin
         shift <= tx_data;
      end
      else if (state == TX_DATA && bit_done)
      begin
         shift <= shift >> 1;
      end
   end

   // Line held at mark while no frame is going out
   assert property (@(posedge clk) disable iff (!reset_b) (state == TX_IDLE) |-> txd);

endmodule

//--- tb.f
+incdir+include
src/sys_pkg.sv
src/uart_pkg.sv
src/addr_decode.sv
src/block_ram.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/heartbeat.sv
src/sys_top.sv
tests/sys_checker.sv
tests/tb_sys_top.sv

//--- tests/sys_checker.sv
`timescale 1ns/1ps
`include "sys_config.svh"

module sys_checker
   import sys_pkg::*;
   import uart_pkg::*;
#(
   parameter int CLK_HZ        = `SYS_CLK_HZ,
   parameter int BAUD          = `SYS_BAUD,
   parameter int RAM_ADDR_BITS = `SYS_RAM_ADDR_BITS
) (
   input  logic       clk,
   input  logic       reset_b,
   input  addr_t      address,
   input  word_t      din,
   input  logic       rnw,
   input  word_t      dout,
   input  logic [3:0] sw,
   input  logic [3:0] led,
   input  logic       rxd,
   input  logic       txd,
   output int         error_total
);

   localparam int BIT_CLKS = CLK_HZ / BAUD;
   localparam addr_t UART_BASE = `SYS_UART_BASE;
   // Bits above the RAM, all set
   localparam addr_t TOP_MASK = 16'hffff >> RAM_ADDR_BITS;

   word_t       model_ram [2**RAM_ADDR_BITS];
   logic [23:0] model_beat;
   int          busy_left;
   logic        rx_wait;
   logic        rx_full;
   logic        rx_seen;
   uart_byte_t  rx_byte;
   uart_byte_t  tx_expect [$];
   string       test_name;
   int          test_errors;
   int          tests_run;
   int          tests_failed;
   int          checks;

   initial
   begin
      error_total = 0;
      test_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      checks = 0;
      rx_seen = 1'b0;
      test_name = "reset";
   end

   task automatic report(input string msg);
      $display("ERROR in %s: %s", test_name, msg);
      error_total++;
      test_errors++;
   endtask

   task automatic compare(input string what, input word_t expected, input word_t actual);
      checks++;
      if (actual !== expected)
      begin
         $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
         error_total++;
         test_errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      // Every accepted write must have shown up on txd by now
      if (tx_expect.size() != 0)
      begin
         report("a byte written to the UART never appeared on txd");
         tx_expect.delete();
      end
      tests_run++;
      if (test_errors == 0)
      begin
         $display("PASS %s", test_name);
      end
      else
      begin
         tests_failed++;
         $display("FAIL %s with %0d errors", test_name, test_errors);
      end
   endtask

   task automatic print_summary();
      $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, checks, error_total);
   endtask

   // Bus, LED and status model, sampled before the edge updates
   always @(posedge clk)
   begin : monitor
      addr_t hi;
      logic  uart_sel;
      logic  ram_sel;
      logic  launch;
      word_t expected;
      if (!reset_b)
      begin
         model_beat = '0;
         busy_left = 0;
         rx_wait = 1'b0;
         rx_full = 1'b0;
      end
      else
      begin
         compare("led", {12'h000, model_beat[23:20] | sw}, {12'h000, led});
         model_beat = model_beat + 1'b1;
         hi = address >> RAM_ADDR_BITS;
         uart_sel = ((address | 16'h0001) == (UART_BASE | 16'h0001));
         // UART wins over the top mirror
         ram_sel = !uart_sel && (hi == '0 || hi == TOP_MASK);
         launch = 1'b0;
         if (rnw)
         begin
            if (uart_sel && address[0])
            begin
               // Byte in flight may land on any cycle
               expected = {14'b0, busy_left != 0, rx_wait ? dout[0] : rx_full};
               compare("status", expected, dout);
               if (rx_wait && dout[0] === 1'b1)
               begin
                  rx_wait = 1'b0;
                  rx_full = 1'b1;
               end
            end
            else if (uart_sel)
            begin
               if (rx_seen)
                  compare("rx data", {8'h00, rx_byte}, dout);
               rx_full = 1'b0;
            end
            else if (ram_sel)
               compare("ram read", model_ram[address[RAM_ADDR_BITS-1:0]], dout);
            else
               compare("unmapped read", 16'hffff, dout);
         end
         else if (uart_sel && !address[0])
         begin
            // Dropped while the last frame is still going out
            launch = (busy_left == 0);
            if (launch)
               tx_expect.push_back(din[7:0]);
         end
         else if (ram_sel)
            model_ram[address[RAM_ADDR_BITS-1:0]] = din;
         // Start, 8 data and stop bits
         if (launch)
            busy_left = 10 * BIT_CLKS;
         else if (busy_left != 0)
            busy_left--;
      end
   end

   // txd decoder, sampled at mid bit
   initial
   begin : txd_decoder
      uart_byte_t got;
      forever
      begin
         @(posedge clk);
         if (reset_b && txd === 1'b0)
         begin
            repeat (BIT_CLKS / 2) @(posedge clk);
            if (txd !== 1'b0)
               report("start bit on txd ended early");
            for (int i = 0; i < 8; i++)
            begin
               repeat (BIT_CLKS) @(posedge clk);
               got[i] = txd;
            end
            repeat (BIT_CLKS) @(posedge clk);
            if (txd !== 1'b1)
               report("stop bit on txd is missing");
            if (tx_expect.size() == 0)
               report("txd sent a frame that no accepted write asked for");
            else
               compare("txd byte", {8'h00, tx_expect.pop_front()}, {8'h00, got});
         end
      end
   end

   // rxd decoder gives the byte the DUT should store
   initial
   begin : rxd_decoder
      uart_byte_t bits;
      forever
      begin
         @(posedge clk);
         if (reset_b && rxd === 1'b0)
         begin
            repeat (BIT_CLKS / 2) @(posedge clk);
            for (int i = 0; i < 8; i++)
            begin
               repeat (BIT_CLKS) @(posedge clk);
               bits[i] = rxd;
            end
            repeat (BIT_CLKS) @(posedge clk);
            if (rxd === 1'b1)
            begin
               rx_byte = bits;
               rx_seen = 1'b1;
               // rx_full may rise any time from mid stop bit
               rx_wait = 1'b1;
            end
            else
               report("frame on rxd has no stop bit");
         end
      end
   end

endmodule

//--- tests/tb_sys_top.sv
`timescale 1ns/1ps
`include "sys_config.svh"

module tb_sys_top
   import sys_pkg::*;
   import uart_pkg::*;
();

   // 16 clocks per bit keeps frames short
   localparam int CLK_HZ = 1600000;
   localparam int BAUD = 100000;
   localparam int RAM_BITS = `SYS_RAM_ADDR_BITS;
   localparam int BIT_CLKS = CLK_HZ / BAUD;
   localparam int FRAME_CLKS = 10 * BIT_CLKS;
   localparam int N_RAM = 200;
   localparam int N_RX = 4;
   // Bus cycles of all tests, two clocks each
   localparam int BUS_OPS = 3 * N_RAM + 8 * N_RX + 16;
   localparam int WATCHDOG_CLKS = 2 * (2 * BUS_OPS + 12 * FRAME_CLKS);
   localparam addr_t IDLE_ADDR = 16'h0100;
   localparam addr_t UART_DATA = `SYS_UART_BASE;
   localparam addr_t UART_STAT = `SYS_UART_BASE + 16'd1;

   logic        clk = 1'b0;
   logic        reset_b;
   addr_t       address;
   word_t       din;
   logic        rnw;
   word_t       dout;
   logic [3:0]  sw;
   logic [3:0]  led;
   logic        rxd;
   logic        txd;
   int          error_total;
   logic [31:0] seed = 32'h8f115f1e;

   always #5 clk = ~clk;

   sys_top #(
      .CLK_HZ        (CLK_HZ),
      .BAUD          (BAUD),
      .RAM_ADDR_BITS (RAM_BITS)
   ) i_sys_top (
      .clk     (clk),
      .reset_b (reset_b),
      .address (address),
      .din     (din),
      .rnw     (rnw),
      .dout    (dout),
      .sw      (sw),
      .led     (led),
      .rxd     (rxd),
      .txd     (txd)
   );

   sys_checker #(
      .CLK_HZ        (CLK_HZ),
      .BAUD          (BAUD),
      .RAM_ADDR_BITS (RAM_BITS)
   ) i_checker (
      .clk         (clk),
      .reset_b     (reset_b),
      .address     (address),
      .din         (din),
      .rnw         (rnw),
      .dout        (dout),
      .sw          (sw),
      .led         (led),
      .rxd         (rxd),
      .txd         (txd),
      .error_total (error_total)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic draw(output logic [31:0] r);
      seed = xorshift(seed);
      r = seed;
   endtask

   // Bottom or top region, both mirrors clear of the UART
   function automatic addr_t pick_ram_addr(input logic [31:0] r);
      addr_t a;
      a = {r[0] ? 4'hf : 4'h0, r[12:1]};
      if ((a | 16'hf001) == (UART_DATA | 16'hf001))
         a = a ^ 16'h0100;
      return a;
   endfunction

   // One bus cycle, then back to idle
   task automatic access(input addr_t a, input word_t d, input logic r_nw, output word_t q);
      @(negedge clk);
      address = a;
      din = d;
      rnw = r_nw;
      @(posedge clk);
      q = dout;
      @(negedge clk);
      address = IDLE_ADDR;
      rnw = 1'b1;
   endtask

   // Write, then status read in the very next cycle
   task automatic write_then_status(input addr_t a, input word_t d, output word_t q);
      @(negedge clk);
      address = a;
      din = d;
      rnw = 1'b0;
      @(negedge clk);
      address = UART_STAT;
      rnw = 1'b1;
      @(posedge clk);
      q = dout;
      @(negedge clk);
      address = IDLE_ADDR;
   endtask

   task automatic poll_status(input int bit_idx, input logic level);
      word_t q;
      int    polls;
      polls = 0;
      do
      begin
         access(UART_STAT, 16'h0000, 1'b1, q);
         polls++;
      end
      while (q[bit_idx] !== level && polls < FRAME_CLKS);
      if (q[bit_idx] !== level)
         i_checker.report($sformatf("status bit %0d never went to %b", bit_idx, level));
   endtask

   // 8N1 frame onto rxd, LSB first
   task automatic send_serial(input uart_byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         @(negedge clk);
         rxd = frame[i];
         repeat (BIT_CLKS - 1) @(negedge clk);
      end
   endtask

   initial
   begin : watchdog
      repeat (WATCHDOG_CLKS) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d clocks", WATCHDOG_CLKS);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial
   begin : stimulus
      logic [31:0] r;
      logic [3:0]  nib;
      addr_t       a;
      word_t       q;
      reset_b = 1'b0;
      address = IDLE_ADDR;
      din = '0;
      rnw = 1'b1;
      sw = '0;
      rxd = 1'b1;
      repeat (2) @(negedge clk);
      reset_b = 1'b1;

      // Counter still zero, so each LED follows its switch
      i_checker.start_test("leds");
      repeat (4) @(negedge clk);
      for (int i = 0; i < 4; i++)
      begin
         sw = 4'b0001 << i;
         repeat (4) @(negedge clk);
      end
      sw = '0;
      repeat (2) @(negedge clk);
      i_checker.end_test();

      i_checker.start_test("ram_mirror");
      access(16'h4000, 16'h0000, 1'b1, q);
      for (int n = 0; n < N_RAM; n++)
      begin
         draw(r);
         a = pick_ram_addr(r);
         access(a, r[31:16], 1'b0, q);
         // Same word seen through the other mirror
         access(a ^ 16'hf000, 16'h0000, 1'b1, q);
         draw(r);
         nib = 4'd1 + r[3:0] % 4'd14;
         access({nib, r[15:4]}, 16'h0000, 1'b1, q);
      end
      i_checker.end_test();

      // fe08 write goes to the UART, not to RAM word e08
      i_checker.start_test("uart_priority");
      draw(r);
      access(16'h0e08, r[15:0], 1'b0, q);
      access(UART_DATA, r[31:16], 1'b0, q);
      access(16'h0e08, 16'h0000, 1'b1, q);
      access(UART_STAT, 16'h0000, 1'b1, q);
      poll_status(1, 1'b0);
      i_checker.end_test();

      i_checker.start_test("uart_tx");
      draw(r);
      write_then_status(UART_DATA, {8'h00, r[7:0]}, q);
      repeat (3 * BIT_CLKS) @(negedge clk);
      // Transmitter busy, so this byte is lost
      access(UART_DATA, {8'h00, r[15:8]}, 1'b0, q);
      poll_status(1, 1'b0);
      // Room for a stray second frame to show
      repeat (FRAME_CLKS) @(negedge clk);
      i_checker.end_test();

      i_checker.start_test("uart_rx");
      for (int n = 0; n < N_RX; n++)
      begin
         draw(r);
         send_serial(r[7:0]);
         poll_status(0, 1'b1);
         access(UART_DATA, 16'h0000, 1'b1, q);
         access(UART_STAT, 16'h0000, 1'b1, q);
      end
      i_checker.end_test();

      i_checker.print_summary();
      if (error_total == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule
